// ==== files.f ====
common/axil_pkg.sv
common/gpio_pkg.sv
gpio/gpio_input_sync.sv
gpio/gpio_regs.sv
logic/axil_xbar.sv
logic/gpio_bridge_top.sv
tests/gpio_bridge_props.sv
tests/tb_gpio_bridge.sv

// ==== Bender.yml ====
package:
  name: gpio_bridge

dependencies: {}

sources:
  # Packages first, then leaf blocks, then the top level
  - common/axil_pkg.sv
  - common/gpio_pkg.sv
  - gpio/gpio_input_sync.sv
  - gpio/gpio_regs.sv
  - logic/axil_xbar.sv
  - logic/gpio_bridge_top.sv

  - target: test
    files:
      - tests/gpio_bridge_props.sv
      - tests/tb_gpio_bridge.sv

// ==== tests/tb_gpio_bridge.sv ====
// Pins are changed only between accesses and are held four cycles before a read
`timescale 1ns/1ps

module tb_gpio_bridge import axil_pkg::*, gpio_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    // About 150 accesses of up to ten cycles each, plus pin settling
    localparam int MAX_CYCLES = 4000;
    localparam int N_LED      = 20;
    localparam int N_SW       = 12;
    localparam int N_IOCON    = 12;
    localparam int N_DECERR   = 16;
    localparam int N_BP       = 40;

    logic       clk;
    logic       rst_i;
    axil_req_t  req;
    logic       req_valid;
    logic       req_ready;
    axil_rsp_t  rsp;
    logic       rsp_valid;
    logic       rsp_ready;
    gpio_pins_t leds;
    gpio_pins_t switches;
    gpio_pins_t iocon_in;
    gpio_pins_t iocon_out;
    gpio_pins_t iocon_oe;
    logic       irq;

    // Register model of both GPIO blocks
    gpio_pins_t m_data [2];
    gpio_pins_t m_tri  [2];
    logic       m_gier [2];
    logic       m_ier  [2];
    logic       m_isr  [2];
    axil_rsp_t  exp_q  [$];

    integer     seed    = 32'hdd1;
    integer     bp_seed = 32'hdd1;
    logic       bp_en;
    logic       pending;
    int         cycles  = 0;
    logic       busy;
    logic       held;
    axil_rsp_t  held_rsp;
    axil_rsp_t  exp_rsp;

    gpio_bridge_top i_dut (
        .axi_aclk_i  (clk),
        .rst_i       (rst_i),
        .req_i       (req),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .rsp_o       (rsp),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .leds_o      (leds),
        .switches_i  (switches),
        .iocon_i     (iocon_in),
        .iocon_o     (iocon_out),
        .iocon_oe_o  (iocon_oe),
        .irq_o       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    function automatic axil_addr_t reg_addr(input int blk, input gpio_offset_t off);
        return ((blk == 0) ? GPIO0_BASE : GPIO1_BASE) | off;
    endfunction

    // Expected response; writes update the model as the DUT accepts them
    function automatic axil_rsp_t model_access(input axil_req_t r);
        axil_rsp_t    res;
        int           blk;
        gpio_offset_t off;
        gpio_pins_t   pins;
        res.rdata = '0;
        res.resp  = RESP_OKAY;
        off       = r.addr[REG_OFFSET_BITS-1:0];
        case (r.addr[31:SLAVE_WINDOW_BITS])
            GPIO0_BASE[31:SLAVE_WINDOW_BITS]: blk = 0;
            GPIO1_BASE[31:SLAVE_WINDOW_BITS]: blk = 1;
            default: blk = -1;
        endcase
        if (blk < 0) begin
            res.resp = RESP_DECERR;
        end else if (r.write) begin
            case (off)
                REG_DATA: begin
                    if (r.strb[0]) begin
                        m_data[blk] = r.wdata[GPIO_WIDTH-1:0];
                    end
                end
                REG_TRI:  m_tri[blk]  = r.wdata[GPIO_WIDTH-1:0];
                REG_GIER: m_gier[blk] = r.wdata[31];
                REG_IER:  m_ier[blk]  = r.wdata[0];
                REG_ISR: begin
                    if (r.wdata[0]) begin
                        m_isr[blk] = 1'b0;
                    end
                end
                default: ;
            endcase
        end else begin
            pins = (blk == 0) ? switches : iocon_in;
            case (off)
                REG_DATA: begin
                    for (int i = 0; i < GPIO_WIDTH; i++) begin
                        res.rdata[i] = m_tri[blk][i] ? pins[i] : m_data[blk][i];
                    end
                end
                REG_TRI:  res.rdata[GPIO_WIDTH-1:0] = m_tri[blk];
                REG_GIER: res.rdata[31] = m_gier[blk];
                REG_IER:  res.rdata[0] = m_ier[blk];
                REG_ISR:  res.rdata[0] = m_isr[blk];
                default:  res.rdata = '0;
            endcase
        end
        return res;
    endfunction

    function automatic gpio_offset_t pick_offset();
        int sel;
        sel = $unsigned($random(seed)) % 6;
        case (sel)
            0: return REG_DATA;
            1: return REG_TRI;
            2: return REG_GIER;
            3: return REG_ISR;
            4: return REG_IER;
            default: return $random(seed);
        endcase
    endfunction

    // Returns after acceptance; the response is checked by the compare process
    task automatic access(input logic wr, input axil_addr_t addr,
                          input axil_data_t wdata, input axil_strb_t strb);
        req       = '{write: wr, addr: addr, wdata: wdata, strb: strb};
        req_valid = 1'b1;
        do begin
            @(posedge clk);
        end while (!req_ready);
        exp_q.push_back(model_access(req));
        pending = 1'b1;
        #1;
        req_valid = 1'b0;
    endtask

    task automatic drain();
        if (pending) begin
            do begin
                @(posedge clk);
            end while (!(rsp_valid && rsp_ready));
            pending = 1'b0;
            #1;
        end
    endtask

    task automatic access_wait(input logic wr, input axil_addr_t addr,
                               input axil_data_t wdata, input axil_strb_t strb);
        access(wr, addr, wdata, strb);
        drain();
    endtask

    task automatic set_pins(input int blk, input gpio_pins_t val);
        gpio_pins_t old;
        old = (blk == 0) ? switches : iocon_in;
        if (val != old) begin
            m_isr[blk] = 1'b1;
        end
        if (blk == 0) begin
            switches = val;
        end else begin
            iocon_in = val;
        end
    endtask

    task automatic settle();
        repeat (4) @(posedge clk);
        #1;
    endtask

    // Random stretches of back-pressure on the response channel
    initial begin
        int stretch;
        stretch   = 0;
        rsp_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (!bp_en) begin
                rsp_ready = 1'b1;
            end else if (stretch == 0) begin
                rsp_ready = ($random(bp_seed) & 1) != 0;
                stretch   = $unsigned($random(bp_seed)) % 6;
            end else begin
                stretch--;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_i) begin
            busy = 1'b0;
            held = 1'b0;
        end else begin
            if (held) begin
                assert (rsp_valid && rsp == held_rsp)
                    else abort_run($sformatf("error at %0t: response lost or changed while stalled",
                                             $time));
            end
            if (req_valid && req_ready) begin
                assert (!busy)
                    else abort_run($sformatf("error at %0t: request accepted during a pending one",
                                             $time));
                busy = 1'b1;
            end
            if (rsp_valid && rsp_ready) begin
                assert (exp_q.size() != 0)
                    else abort_run("a response arrived without an accepted request");
                exp_rsp = exp_q.pop_front();
                assert (rsp == exp_rsp)
                    else abort_run($sformatf("error at %0t: resp %0d data %h, expected %0d data %h",
                                             $time, rsp.resp, rsp.rdata, exp_rsp.resp,
                                             exp_rsp.rdata));
                busy = 1'b0;
            end
            held     = rsp_valid && !rsp_ready;
            held_rsp = rsp;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("timeout: the test did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        axil_data_t d;
        axil_addr_t a;
        gpio_pins_t v;
        logic       seen;
        rst_i     = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        switches  = '0;
        iocon_in  = '0;
        bp_en     = 1'b0;
        pending   = 1'b0;
        for (int b = 0; b < 2; b++) begin
            m_data[b] = '0;
            m_tri[b]  = '1;
            m_gier[b] = 1'b0;
            m_ier[b]  = 1'b0;
            m_isr[b]  = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_i = 1'b0;
        assert (req_ready && !rsp_valid && !irq && leds == 0 && iocon_out == 0 && iocon_oe == 0)
            else abort_run($sformatf("error at %0t: outputs not at their reset values", $time));

        // LEDs driven with random strobes
        access_wait(1'b1, reg_addr(0, REG_TRI), 32'h0, 4'hf);
        for (int i = 0; i < N_LED; i++) begin
            access_wait(1'b1, reg_addr(0, REG_DATA), $random(seed), $random(seed));
            assert (leds == m_data[0])
                else abort_run($sformatf("error at %0t: leds %h, expected %h",
                                         $time, leds, m_data[0]));
            access_wait(1'b0, reg_addr(0, REG_DATA), '0, '0);
        end

        // Switches read back with the default direction
        access_wait(1'b1, reg_addr(0, REG_TRI), 32'hff, 4'hf);
        for (int i = 0; i < N_SW; i++) begin
            set_pins(0, $random(seed));
            settle();
            access_wait(1'b0, reg_addr(0, REG_DATA), '0, '0);
        end

        for (int i = 0; i < N_IOCON; i++) begin
            access_wait(1'b1, reg_addr(1, REG_TRI), $random(seed), 4'hf);
            access_wait(1'b1, reg_addr(1, REG_DATA), $random(seed), 4'h1);
            assert (iocon_oe == ~m_tri[1] && iocon_out == m_data[1])
                else abort_run($sformatf("error at %0t: iocon %h oe %h, expected %h oe %h",
                                         $time, iocon_out, iocon_oe, m_data[1], ~m_tri[1]));
            set_pins(1, $random(seed));
            settle();
            access_wait(1'b0, reg_addr(1, REG_DATA), '0, '0);
        end

        for (int i = 0; i < N_DECERR; i++) begin
            a     = $random(seed);
            a[31] = 1'b1;
            d     = $random(seed);
            access_wait(d[0], a, d, 4'hf);
            assert (leds == m_data[0] && iocon_out == m_data[1] && iocon_oe == ~m_tri[1])
                else abort_run($sformatf("error at %0t: pins changed by an unmapped access",
                                         $time));
        end

        // Interrupt from a switch change
        access_wait(1'b1, reg_addr(0, REG_ISR), 32'h1, 4'hf);
        access_wait(1'b1, reg_addr(0, REG_GIER), 32'h8000_0000, 4'hf);
        access_wait(1'b1, reg_addr(0, REG_IER), 32'h1, 4'hf);
        assert (!irq) else abort_run($sformatf("error at %0t: irq high before a change", $time));
        v = $random(seed);
        set_pins(0, switches ^ (v | 8'h01));
        seen = 1'b0;
        repeat (5) begin
            @(posedge clk);
            if (irq) begin
                seen = 1'b1;
            end
        end
        #1;
        assert (seen) else abort_run($sformatf("error at %0t: irq missing after change", $time));
        access_wait(1'b0, reg_addr(0, REG_ISR), '0, '0);
        access_wait(1'b1, reg_addr(0, REG_ISR), 32'h1, 4'hf);
        assert (!irq) else abort_run($sformatf("error at %0t: irq high after clear", $time));
        access_wait(1'b1, reg_addr(0, REG_IER), 32'h0, 4'hf);
        set_pins(0, ~switches);
        repeat (6) begin
            @(posedge clk);
            assert (!irq)
                else abort_run($sformatf("error at %0t: irq high with IER clear", $time));
        end
        #1;
        access_wait(1'b0, reg_addr(0, REG_ISR), '0, '0);

        // Back-to-back requests against random back-pressure
        bp_en = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            d        = $random(seed);
            a        = reg_addr(d[8], pick_offset());
            a[15:9]  = d[22:16];
            access(d[9], a, $random(seed), $random(seed));
        end
        drain();
        bp_en = 1'b0;

        if (exp_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run("responses were still missing at the end of the run");
        end
    end

endmodule

// ==== tests/gpio_bridge_props.sv ====
// Covers the crossbar's outside handshake only; slave-side channels are not checked
`timescale 1ns/1ps

module gpio_bridge_props import axil_pkg::*; (
    input logic      axi_aclk_i,
    input logic      rst_i,
    input logic      req_valid_i,
    input logic      req_ready_o,
    input axil_rsp_t rsp_o,
    input logic      rsp_valid_o,
    input logic      rsp_ready_i
);

    // Busy from acceptance until the response is taken
    property ready_low_while_busy;
        @(posedge axi_aclk_i) disable iff (rst_i)
        (req_valid_i && req_ready_o) || (!req_ready_o && !(rsp_valid_o && rsp_ready_i))
        |=> !req_ready_o;
    endproperty

    property rsp_held_under_backpressure;
        @(posedge axi_aclk_i) disable iff (rst_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o);
    endproperty

    property no_rsp_after_reset;
        @(posedge axi_aclk_i) $past(rst_i) |-> !rsp_valid_o;
    endproperty

    a_ready_low: assert property (ready_low_while_busy)
        else $error("req_ready_o high while a transaction is in flight");
    a_rsp_hold: assert property (rsp_held_under_backpressure)
        else $error("rsp_o changed or dropped while rsp_ready_i was low");
    a_rsp_reset: assert property (no_rsp_after_reset)
        else $error("rsp_valid_o high in the cycle after reset");

endmodule

bind axil_xbar gpio_bridge_props u_props (
    .axi_aclk_i  (axi_aclk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
);

// ==== logic/gpio_bridge_top.sv ====
// Single clock domain; bidirectional header pins split into in, out and enable
`timescale 1ns/1ps

module gpio_bridge_top import axil_pkg::*, gpio_pkg::*; (
    input  logic       axi_aclk_i,
    input  logic       rst_i,

    input  axil_req_t  req_i,
    input  logic       req_valid_i,
    output logic       req_ready_o,

    output axil_rsp_t  rsp_o,
    output logic       rsp_valid_o,
    input  logic       rsp_ready_i,

    output gpio_pins_t leds_o,
    input  gpio_pins_t switches_i,
    input  gpio_pins_t iocon_i,
    output gpio_pins_t iocon_o,
    output gpio_pins_t iocon_oe_o,

    output logic       irq_o
);

    axil_req_t       slv_req;
    logic      [1:0] slv_req_valid;
    logic      [1:0] slv_req_ready;
    axil_rsp_t [1:0] slv_rsp;
    logic      [1:0] slv_rsp_valid;
    logic      [1:0] slv_rsp_ready;
    gpio_pins_t      iocon_tri;
    logic            irq_leds;
    logic            irq_iocon;

    axil_xbar u_xbar (
        .axi_aclk_i      (axi_aclk_i),
        .rst_i           (rst_i),
        .req_i           (req_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .rsp_o           (rsp_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .slv_req_o       (slv_req),
        .slv_req_valid_o (slv_req_valid),
        .slv_req_ready_i (slv_req_ready),
        .slv_rsp_i       (slv_rsp),
        .slv_rsp_valid_i (slv_rsp_valid),
        .slv_rsp_ready_o (slv_rsp_ready)
    );

    // LEDs out, switches in
    gpio_regs u_gpio_leds (
        .axi_aclk_i  (axi_aclk_i),
        .rst_i       (rst_i),
        .req_i       (slv_req),
        .req_valid_i (slv_req_valid[0]),
        .req_ready_o (slv_req_ready[0]),
        .rsp_o       (slv_rsp[0]),
        .rsp_valid_o (slv_rsp_valid[0]),
        .rsp_ready_i (slv_rsp_ready[0]),
        .pins_i      (switches_i),
        .pins_o      (leds_o),
        .tri_o       (),
        .irq_o       (irq_leds)
    );

    gpio_regs u_gpio_iocon (
        .axi_aclk_i  (axi_aclk_i),
        .rst_i       (rst_i),
        .req_i       (slv_req),
        .req_valid_i (slv_req_valid[1]),
        .req_ready_o (slv_req_ready[1]),
        .rsp_o       (slv_rsp[1]),
        .rsp_valid_o (slv_rsp_valid[1]),
        .rsp_ready_i (slv_rsp_ready[1]),
        .pins_i      (iocon_i),
        .pins_o      (iocon_o),
        .tri_o       (iocon_tri),
        .irq_o       (irq_iocon)
    );

    // Direction bit 0 drives the pin
    assign iocon_oe_o = ~iocon_tri;
    assign irq_o      = irq_leds | irq_iocon;

endmodule

// ==== logic/axil_xbar.sv ====
// One transaction in flight; two slaves fixed at GPIO0_BASE and GPIO1_BASE
`timescale 1ns/1ps

module axil_xbar import axil_pkg::*, gpio_pkg::*; (
    input  logic            axi_aclk_i,
    input  logic            rst_i,

    input  axil_req_t       req_i,
    input  logic            req_valid_i,
    output logic            req_ready_o,

    output axil_rsp_t       rsp_o,
    output logic            rsp_valid_o,
    input  logic            rsp_ready_i,

    output axil_req_t       slv_req_o,
    output logic      [1:0] slv_req_valid_o,
    input  logic      [1:0] slv_req_ready_i,

    input  axil_rsp_t [1:0] slv_rsp_i,
    input  logic      [1:0] slv_rsp_valid_i,
    output logic      [1:0] slv_rsp_ready_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FORWARD,
        ST_WAIT_RSP,
        ST_RESPOND
    } xbar_state_e;

    xbar_state_e state_q;
    axil_req_t   req_q;
    axil_req_t   fwd_req;
    axil_rsp_t   rsp_q;
    logic        sel_q;
    logic        hit0;
    logic        hit1;
    logic        req_fire;

    // Compare only the bits above the slave window
    assign hit0 = req_i.addr[AXIL_ADDR_WIDTH-1:SLAVE_WINDOW_BITS] ==
                  GPIO0_BASE[AXIL_ADDR_WIDTH-1:SLAVE_WINDOW_BITS];
    assign hit1 = req_i.addr[AXIL_ADDR_WIDTH-1:SLAVE_WINDOW_BITS] ==
                  GPIO1_BASE[AXIL_ADDR_WIDTH-1:SLAVE_WINDOW_BITS];

    assign req_fire = req_valid_i && (state_q == ST_IDLE);

    // Slaves see the register offset only
    always_comb begin
        fwd_req = req_i;
        fwd_req.addr = '0;
        fwd_req.addr[REG_OFFSET_BITS-1:0] = req_i.addr[REG_OFFSET_BITS-1:0];
    end

    always_ff @(posedge axi_aclk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= (hit0 || hit1) ? ST_FORWARD : ST_RESPOND;
                    end
                end
                ST_FORWARD: begin
                    if (slv_req_ready_i[sel_q]) begin
                        state_q <= ST_WAIT_RSP;
                    end
                end
                ST_WAIT_RSP: begin
                    if (slv_rsp_valid_i[sel_q]) begin
                        state_q <= ST_RESPOND;
                    end
                end
                default: begin
                    if (rsp_ready_i) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge axi_aclk_i) begin
        if (req_fire) begin
            req_q <= fwd_req;
            sel_q <= hit1;
        end
        if (req_fire && !(hit0 || hit1)) begin
            rsp_q <= '{rdata: '0, resp: RESP_DECERR};
        end else if (state_q == ST_WAIT_RSP && slv_rsp_valid_i[sel_q]) begin
            rsp_q <= slv_rsp_i[sel_q];
        end
    end

    assign req_ready_o = (state_q == ST_IDLE);
    assign rsp_valid_o = (state_q == ST_RESPOND);
    assign rsp_o       = rsp_q;
    assign slv_req_o   = req_q;

    assign slv_req_valid_o = {(state_q == ST_FORWARD) &&  sel_q,
                              (state_q == ST_FORWARD) && !sel_q};
    assign slv_rsp_ready_o = {(state_q == ST_WAIT_RSP) &&  sel_q,
                              (state_q == ST_WAIT_RSP) && !sel_q};

endmodule

// ==== gpio/gpio_regs.sv ====
// Single channel GPIO; unknown offsets read zero and always answer OKAY
`timescale 1ns/1ps

module gpio_regs import axil_pkg::*, gpio_pkg::*; (
    input  logic       axi_aclk_i,
    input  logic       rst_i,

    input  axil_req_t  req_i,
    input  logic       req_valid_i,
    output logic       req_ready_o,

    output axil_rsp_t  rsp_o,
    output logic       rsp_valid_o,
    input  logic       rsp_ready_i,

    input  gpio_pins_t pins_i,
    output gpio_pins_t pins_o,
    output gpio_pins_t tri_o,

    output logic       irq_o
);

    logic         rsp_valid_q;
    axil_rsp_t    rsp_q;
    gpio_pins_t   data_q;
    gpio_pins_t   tri_q;
    gpio_pins_t   pins_sync;
    logic         pins_changed;
    logic         gier_q;
    logic         ier_q;
    logic         isr_q;
    logic         req_fire;
    logic         wr_fire;
    gpio_offset_t offset;
    axil_data_t   rdata;

    gpio_input_sync u_sync (
        .axi_aclk_i (axi_aclk_i),
        .rst_i      (rst_i),
        .pins_i     (pins_i),
        .sync_o     (pins_sync),
        .changed_o  (pins_changed)
    );

    assign req_ready_o = !rsp_valid_q;
    assign req_fire    = req_valid_i && !rsp_valid_q;
    assign wr_fire     = req_fire && req_i.write;
    assign offset      = req_i.addr[REG_OFFSET_BITS-1:0];

    always_comb begin
        rdata = '0;
        case (offset)
            // Inputs where tri is 1, output register elsewhere
            REG_DATA: rdata[GPIO_WIDTH-1:0] = (pins_sync & tri_q) | (data_q & ~tri_q);
            REG_TRI:  rdata[GPIO_WIDTH-1:0] = tri_q;
            REG_GIER: rdata[31] = gier_q;
            REG_IER:  rdata[0]  = ier_q;
            REG_ISR:  rdata[0]  = isr_q;
            default:  rdata = '0;
        endcase
    end

    always_ff @(posedge axi_aclk_i) begin
        if (rst_i) begin
            rsp_valid_q <= 1'b0;
            data_q      <= '0;
            tri_q       <= '1;
            gier_q      <= 1'b0;
            ier_q       <= 1'b0;
            isr_q       <= 1'b0;
        end else begin
            if (req_fire) begin
                rsp_valid_q <= 1'b1;
            end else if (rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end

            if (wr_fire && offset == REG_DATA && req_i.strb[0]) begin
                data_q <= req_i.wdata[GPIO_WIDTH-1:0];
            end
            if (wr_fire && offset == REG_TRI) begin
                tri_q <= req_i.wdata[GPIO_WIDTH-1:0];
            end
            if (wr_fire && offset == REG_GIER) begin
                gier_q <= req_i.wdata[31];
            end
            if (wr_fire && offset == REG_IER) begin
                ier_q <= req_i.wdata[0];
            end

            // A new change wins over a clear in the same cycle
            if (pins_changed) begin
                isr_q <= 1'b1;
            end else if (wr_fire && offset == REG_ISR && req_i.wdata[0]) begin
                isr_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge axi_aclk_i) begin
        if (req_fire) begin
            rsp_q.rdata <= req_i.write ? '0 : rdata;
            rsp_q.resp  <= RESP_OKAY;
        end
    end

    assign rsp_o       = rsp_q;
    assign rsp_valid_o = rsp_valid_q;
    assign pins_o      = data_q;
    assign tri_o       = tri_q;
    assign irq_o       = gier_q && ier_q && isr_q;

endmodule

// ==== gpio/gpio_input_sync.sv ====
// Two-flop synchronizer per pin; pins must be quasi-static, no bus coherence
`timescale 1ns/1ps

module gpio_input_sync import gpio_pkg::*; (
    input  logic       axi_aclk_i,
    input  logic       rst_i,
    input  gpio_pins_t pins_i,
    output gpio_pins_t sync_o,
    output logic       changed_o
);

    gpio_pins_t meta_q;
    gpio_pins_t sync_q;
    gpio_pins_t prev_q;

    always_ff @(posedge axi_aclk_i) begin
        // Preload with the pins so leaving reset flags no change
        if (rst_i) begin
            meta_q <= pins_i;
            sync_q <= pins_i;
            prev_q <= pins_i;
        end else begin
            meta_q <= pins_i;
            sync_q <= meta_q;
            prev_q <= sync_q;
        end
    end

    assign sync_o    = sync_q;
    assign changed_o = (sync_q != prev_q);

endmodule

// ==== common/gpio_pkg.sv ====
// Two GPIO slaves of eight pins each, 64 KiB apart; only nine offset bits decoded
package gpio_pkg;

    localparam int GPIO_WIDTH = 8;

    typedef logic [GPIO_WIDTH-1:0] gpio_pins_t;

    // Slave windows
    localparam logic [31:0] GPIO0_BASE        = 32'h0000_0000;
    localparam logic [31:0] GPIO1_BASE        = 32'h0001_0000;
    localparam int          SLAVE_WINDOW_BITS = 16;

    localparam int REG_OFFSET_BITS = 9;

    typedef logic [REG_OFFSET_BITS-1:0] gpio_offset_t;

    // Register map of one GPIO block
    localparam gpio_offset_t REG_DATA = 9'h000;
    localparam gpio_offset_t REG_TRI  = 9'h004;
    localparam gpio_offset_t REG_GIER = 9'h11C;
    localparam gpio_offset_t REG_ISR  = 9'h120;
    localparam gpio_offset_t REG_IER  = 9'h128;

endpackage

// ==== common/axil_pkg.sv ====
// Single-beat register bus only; no bursts, no IDs, no protection bits
package axil_pkg;

    localparam int AXIL_ADDR_WIDTH = 32;
    localparam int AXIL_DATA_WIDTH = 32;
    localparam int AXIL_STRB_WIDTH = AXIL_DATA_WIDTH / 8;

    typedef logic [AXIL_ADDR_WIDTH-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_WIDTH-1:0] axil_data_t;
    typedef logic [AXIL_STRB_WIDTH-1:0] axil_strb_t;
    typedef logic [1:0]                 axil_resp_t;

    // Same codes as AXI
    localparam axil_resp_t RESP_OKAY   = 2'd0;
    localparam axil_resp_t RESP_DECERR = 2'd3;

    // Read and write share one request channel
    typedef struct packed {
        logic       write;
        axil_addr_t addr;
        axil_data_t wdata;
        axil_strb_t strb;
    } axil_req_t;

    // Read data is zero for writes
    typedef struct packed {
        axil_data_t rdata;
        axil_resp_t resp;
    } axil_rsp_t;

endpackage
